/* Makefile */
TOP := md5CrackTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* src/candidateDecode.sv */
`timescale 1ns/10ps

module candidateDecode (
  input  logic            CLK,
  input  logic            reset,
  input  md5Pkg::word_t   candidate,
  input  logic            candidateValid,
  input  md5Pkg::digest_t target,
  input  logic            targetLoad,
  output md5Pkg::word_t   msgWord,
  output md5Pkg::word_t   stateA,
  output md5Pkg::word_t   stateB,
  output md5Pkg::word_t   stateC,
  output md5Pkg::word_t   stateD,
  output logic            decValid,
  output md5Pkg::word_t   decCandidate,
  output md5Pkg::word_t   targetA,
  output md5Pkg::word_t   targetB,
  output md5Pkg::word_t   targetC,
  output md5Pkg::word_t   targetD
);
  import md5Pkg::*;

  function automatic word_t byteSwap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // every item starts from the standard chaining values
  assign stateA = InitA;
  assign stateB = InitB;
  assign stateC = InitC;
  assign stateD = InitD;

  always_ff @(posedge CLK)
  begin
    decCandidate <= candidate;
    msgWord      <= byteSwap(candidate);
  end

  always_ff @(posedge CLK)
  begin
    if (reset)
      decValid <= 1'b0;
    else
      decValid <= candidateValid;
  end

  // target held as little-endian words, same order as the end state
  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      targetA <= '0;
      targetB <= '0;
      targetC <= '0;
      targetD <= '0;
    end
    else if (targetLoad)
    begin
      targetA <= byteSwap(target[127:96]);
      targetB <= byteSwap(target[95:64]);
      targetC <= byteSwap(target[63:32]);
      targetD <= byteSwap(target[31:0]);
    end
  end

endmodule

/* src/digestCompare.sv */
`timescale 1ns/10ps

module digestCompare (
  input  logic          CLK,
  input  logic          reset,
  input  md5Pkg::word_t endA,
  input  md5Pkg::word_t endB,
  input  md5Pkg::word_t endC,
  input  md5Pkg::word_t endD,
  input  logic          endValid,
  input  md5Pkg::word_t endCandidate,
  input  md5Pkg::word_t targetA,
  input  md5Pkg::word_t targetB,
  input  md5Pkg::word_t targetC,
  input  md5Pkg::word_t targetD,
  output logic          found,
  output md5Pkg::word_t matchCandidate
);
  import md5Pkg::*;

  word_t digA;
  word_t digB;
  word_t digC;
  word_t digD;
  logic  hit;

  // final chaining addition
  assign digA = endA + InitA;
  assign digB = endB + InitB;
  assign digC = endC + InitC;
  assign digD = endD + InitD;

  assign hit = endValid && (digA == targetA) && (digB == targetB) &&
               (digC == targetC) && (digD == targetD);

  always_ff @(posedge CLK)
  begin
    if (reset)
      found <= 1'b0;
    else
      found <= hit;
  end

  // candidate kept until the next match
  always_ff @(posedge CLK)
  begin
    if (hit && !reset)
      matchCandidate <= endCandidate;
  end

endmodule

/* src/md5CrackTop.sv */
`timescale 1ns/10ps

module md5CrackTop #(
  parameter int StepsPerCycle = 1
) (
  input  logic            CLK,
  input  logic            reset,
  input  md5Pkg::word_t   candidate,
  input  logic            candidateValid,
  input  md5Pkg::digest_t target,
  input  logic            targetLoad,
  output logic            found,
  output md5Pkg::word_t   matchCandidate
);
  import md5Pkg::*;

  //********************************************************************
  // decode to execute to result
  //********************************************************************

  word_t msgWord;
  word_t stateA;
  word_t stateB;
  word_t stateC;
  word_t stateD;
  logic  decValid;
  word_t decCandidate;
  word_t targetA;
  word_t targetB;
  word_t targetC;
  word_t targetD;
  word_t endA;
  word_t endB;
  word_t endC;
  word_t endD;
  logic  endValid;
  word_t endCandidate;

  candidateDecode candidateDecode_i (
    .CLK(CLK),
    .reset(reset),
    .candidate(candidate),
    .candidateValid(candidateValid),
    .target(target),
    .targetLoad(targetLoad),
    .msgWord(msgWord),
    .stateA(stateA),
    .stateB(stateB),
    .stateC(stateC),
    .stateD(stateD),
    .decValid(decValid),
    .decCandidate(decCandidate),
    .targetA(targetA),
    .targetB(targetB),
    .targetC(targetC),
    .targetD(targetD)
  );

  md5RoundPipeline #(
    .StepsPerCycle(StepsPerCycle)
  ) md5RoundPipeline_i (
    .CLK(CLK),
    .reset(reset),
    .inA(stateA),
    .inB(stateB),
    .inC(stateC),
    .inD(stateD),
    .msgWord(msgWord),
    .inValid(decValid),
    .inCandidate(decCandidate),
    .endA(endA),
    .endB(endB),
    .endC(endC),
    .endD(endD),
    .endValid(endValid),
    .endCandidate(endCandidate)
  );

  digestCompare digestCompare_i (
    .CLK(CLK),
    .reset(reset),
    .endA(endA),
    .endB(endB),
    .endC(endC),
    .endD(endD),
    .endValid(endValid),
    .endCandidate(endCandidate),
    .targetA(targetA),
    .targetB(targetB),
    .targetC(targetC),
    .targetD(targetD),
    .found(found),
    .matchCandidate(matchCandidate)
  );

endmodule

/* src/md5Pkg.sv */
package md5Pkg;

  typedef logic [31:0]  word_t;
  typedef logic [127:0] digest_t;
  typedef logic [5:0]   stepIdx_t;

  localparam int NumSteps = 64;

  // chaining values before step 0
  localparam word_t InitA = 32'h67452301;
  localparam word_t InitB = 32'hefcdab89;
  localparam word_t InitC = 32'h98badcfe;
  localparam word_t InitD = 32'h10325476;

  //********************************************************************
  // per-step tables
  //********************************************************************

  localparam word_t StepK [NumSteps] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // each round cycles through four rotate amounts
  localparam logic [4:0] RotTable [16] = '{
    5'd7, 5'd12, 5'd17, 5'd22,
    5'd5, 5'd9,  5'd14, 5'd20,
    5'd4, 5'd11, 5'd16, 5'd23,
    5'd6, 5'd10, 5'd15, 5'd21
  };

  function automatic logic [1:0] roundOf(input stepIdx_t s);
    return s[5:4];
  endfunction

  function automatic word_t stepConstant(input stepIdx_t s);
    return StepK[s];
  endfunction

  function automatic logic [4:0] rotateAmount(input stepIdx_t s);
    return RotTable[{s[5:4], s[1:0]}];
  endfunction

  // message word used by a step with arithmetic mod 16
  function automatic logic [3:0] messageIndex(input stepIdx_t s);
    logic [3:0] low;
    low = s[3:0];
    case (roundOf(s))
      2'd0:    return low;
      2'd1:    return low * 4'd5 + 4'd1;
      2'd2:    return low * 4'd3 + 4'd5;
      default: return low * 4'd7;
    endcase
  endfunction

endpackage

/* src/md5RoundPipeline.sv */
`timescale 1ns/10ps

module md5RoundPipeline #(
  parameter int StepsPerCycle = 1
) (
  input  logic          CLK,
  input  logic          reset,
  input  md5Pkg::word_t inA,
  input  md5Pkg::word_t inB,
  input  md5Pkg::word_t inC,
  input  md5Pkg::word_t inD,
  input  md5Pkg::word_t msgWord,
  input  logic          inValid,
  input  md5Pkg::word_t inCandidate,
  output md5Pkg::word_t endA,
  output md5Pkg::word_t endB,
  output md5Pkg::word_t endC,
  output md5Pkg::word_t endD,
  output logic          endValid,
  output md5Pkg::word_t endCandidate
);
  import md5Pkg::*;

  localparam int NumStages = NumSteps / StepsPerCycle;

  // stage boundaries, index 0 is the pipeline input
  word_t stA [NumStages+1];
  word_t stB [NumStages+1];
  word_t stC [NumStages+1];
  word_t stD [NumStages+1];
  word_t stMsg [NumStages+1];
  word_t stCand [NumStages+1];
  logic  stValid [NumStages+1];

  assign stA[0]     = inA;
  assign stB[0]     = inB;
  assign stC[0]     = inC;
  assign stD[0]     = inD;
  assign stMsg[0]   = msgWord;
  assign stCand[0]  = inCandidate;
  assign stValid[0] = inValid;

  for (genvar k = 0; k < NumStages; k++)
  begin : gStage
    word_t chainA [StepsPerCycle+1];
    word_t chainB [StepsPerCycle+1];
    word_t chainC [StepsPerCycle+1];
    word_t chainD [StepsPerCycle+1];

    assign chainA[0] = stA[k];
    assign chainB[0] = stB[k];
    assign chainC[0] = stC[k];
    assign chainD[0] = stD[k];

    // combinational steps sharing this register stage
    for (genvar j = 0; j < StepsPerCycle; j++)
    begin : gStep
      md5Step #(
        .Step(stepIdx_t'(k * StepsPerCycle + j))
      ) md5Step_i (
        .inA(chainA[j]),
        .inB(chainB[j]),
        .inC(chainC[j]),
        .inD(chainD[j]),
        .msgWord(stMsg[k]),
        .outA(chainA[j+1]),
        .outB(chainB[j+1]),
        .outC(chainC[j+1]),
        .outD(chainD[j+1])
      );
    end

    always_ff @(posedge CLK)
    begin
      stA[k+1]    <= chainA[StepsPerCycle];
      stB[k+1]    <= chainB[StepsPerCycle];
      stC[k+1]    <= chainC[StepsPerCycle];
      stD[k+1]    <= chainD[StepsPerCycle];
      stMsg[k+1]  <= stMsg[k];
      stCand[k+1] <= stCand[k];
    end

    always_ff @(posedge CLK)
    begin
      if (reset)
        stValid[k+1] <= 1'b0;
      else
        stValid[k+1] <= stValid[k];
    end
  end

  assign endA         = stA[NumStages];
  assign endB         = stB[NumStages];
  assign endC         = stC[NumStages];
  assign endD         = stD[NumStages];
  assign endValid     = stValid[NumStages];
  assign endCandidate = stCand[NumStages];

endmodule

/* src/md5Step.sv */
`timescale 1ns/10ps

module md5Step #(
  parameter md5Pkg::stepIdx_t Step = '0
) (
  input  md5Pkg::word_t inA,
  input  md5Pkg::word_t inB,
  input  md5Pkg::word_t inC,
  input  md5Pkg::word_t inD,
  input  md5Pkg::word_t msgWord,
  output md5Pkg::word_t outA,
  output md5Pkg::word_t outB,
  output md5Pkg::word_t outC,
  output md5Pkg::word_t outD
);
  import md5Pkg::*;

  localparam logic [1:0] RoundNum = roundOf(Step);
  localparam word_t      K        = stepConstant(Step);
  localparam int         Rot      = int'(rotateAmount(Step));
  // only word 0 of the block is nonzero
  localparam logic       AddsMsg  = (messageIndex(Step) == 4'd0);

  word_t mixed;
  word_t sum;

  always_comb
  begin
    case (RoundNum)
      2'd0:    mixed = (inB & inC) | (~inB & inD);
      2'd1:    mixed = (inD & inB) | (~inD & inC);
      2'd2:    mixed = inB ^ inC ^ inD;
      default: mixed = inC ^ (inB | ~inD);
    endcase
  end

  assign sum = mixed + inA + K + (AddsMsg ? msgWord : '0);

  // rotate left, then shift the words round
  assign outB = inB + ((sum << Rot) | (sum >> (32 - Rot)));
  assign outA = inD;
  assign outD = inC;
  assign outC = inB;

endmodule

/* tb.f */
+incdir+verification
src/md5Pkg.sv
src/candidateDecode.sv
src/md5Step.sv
src/md5RoundPipeline.sv
src/digestCompare.sv
src/md5CrackTop.sv
verification/md5Checker.sv
verification/md5Crack_props.sv
verification/md5CrackTb.sv

/* verification/md5RefModel.svh */
// MD5 of one 512-bit block, only message word 0 nonzero

function automatic logic [31:0] refSwap(input logic [31:0] w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// additive constant, floor(abs(sin(i + 1)) * 2^32)
function automatic logic [31:0] refSine(input int i);
  real s;
  real hi;
  real lo;
  s = $sin(i + 1.0);
  if (s < 0.0)
    s = -s;
  hi = $floor(s * 65536.0);
  lo = $floor(s * 4294967296.0 - hi * 65536.0);
  return {16'($rtoi(hi)), 16'($rtoi(lo))};
endfunction

function automatic logic [127:0] md5Digest(input logic [31:0] cand);
  int          shifts [16] = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  logic [31:0] f;
  logic [31:0] t;
  int          g;
  int          sh;
  a = 32'h67452301;
  b = 32'hefcdab89;
  c = 32'h98badcfe;
  d = 32'h10325476;
  for (int i = 0; i < 64; i++)
  begin
    case (i / 16)
      0:       f = (b & c) | (~b & d);
      1:       f = (d & b) | (~d & c);
      2:       f = b ^ c ^ d;
      default: f = c ^ (b | ~d);
    endcase
    case (i / 16)
      0:       g = i;
      1:       g = (5 * i + 1) % 16;
      2:       g = (3 * i + 5) % 16;
      default: g = (7 * i) % 16;
    endcase
    sh = shifts[(i / 16) * 4 + i % 4];
    t = a + f + refSine(i) + ((g == 0) ? refSwap(cand) : 32'h0);
    a = d;
    d = c;
    c = b;
    b = b + ((t << sh) | (t >> (32 - sh)));
  end
  // digest bytes in the usual hex order
  return {refSwap(a + 32'h67452301), refSwap(b + 32'hefcdab89),
          refSwap(c + 32'h98badcfe), refSwap(d + 32'h10325476)};
endfunction

/* verification/md5Checker.sv */
`timescale 1ns/10ps

module md5Checker #(
  parameter int StepsPerCycle = 1
) (
  input  logic            CLK,
  input  logic            reset,
  input  md5Pkg::word_t   candidate,
  input  logic            candidateValid,
  input  md5Pkg::digest_t target,
  input  logic            targetLoad,
  input  logic            found,
  input  md5Pkg::word_t   matchCandidate,
  input  int              testId,
  input  logic            runDone,
  output int              errorCount,
  output logic            reportDone
);
  import md5Pkg::*;

  `include "md5RefModel.svh"

  localparam int Latency = NumSteps / StepsPerCycle + 2;

  logic    validQ [$];
  word_t   candQ [$];
  digest_t digestQ [$];
  // target after the last edge, and after the one before
  digest_t heldNow;
  digest_t heldPrev;
  word_t   expMatch;
  logic    haveMatch;
  int      curTest;
  int      testChecks;
  int      testErrors;
  int      totalChecks;
  int      testsDone;

  function automatic string testName(input int id);
    case (id)
      1:       return "reset quiet";
      2:       return "planted match";
      3:       return "no false hits";
      4:       return "full throughput";
      5:       return "target reload";
      default: return "unnamed";
    endcase
  endfunction

  task automatic compareValue(input string name, input word_t expected, input word_t actual);
    testChecks++;
    totalChecks++;
    if (actual !== expected)
    begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      testErrors++;
      errorCount++;
    end
  endtask

  task automatic reportTest();
    $display("test %0d (%s): %0d checks, %0d errors",
             curTest, testName(curTest), testChecks, testErrors);
    testsDone++;
    testChecks = 0;
    testErrors = 0;
  endtask

  initial
  begin
    errorCount = 0;
    reportDone = 1'b0;
    haveMatch = 1'b0;
    curTest = 1;
    testChecks = 0;
    testErrors = 0;
    totalChecks = 0;
    testsDone = 0;
  end

  //********************************************************************
  // predicted found and matchCandidate, L edges after the candidate
  //********************************************************************

  always @(posedge CLK)
  begin : watch
    logic    expFound;
    logic    itemValid;
    word_t   itemCand;
    digest_t itemDigest;
    if (reset)
    begin
      validQ.delete();
      candQ.delete();
      digestQ.delete();
      heldNow = '0;
      heldPrev = '0;
    end
    else
    begin
      expFound = 1'b0;
      if (validQ.size() == Latency)
      begin
        itemValid = validQ.pop_front();
        itemCand = candQ.pop_front();
        itemDigest = digestQ.pop_front();
        expFound = itemValid && (itemDigest == heldPrev);
        if (expFound)
        begin
          expMatch = itemCand;
          haveMatch = 1'b1;
        end
      end
      compareValue("found", word_t'(expFound), word_t'(found));
      if (haveMatch)
        compareValue("matchCandidate", expMatch, matchCandidate);
      heldPrev = heldNow;
      if (targetLoad)
        heldNow = target;
      validQ.push_back(candidateValid);
      candQ.push_back(candidate);
      digestQ.push_back(candidateValid ? md5Digest(candidate) : '0);
    end
    if (testId != curTest)
    begin
      reportTest();
      curTest = testId;
    end
    if (runDone && !reportDone)
    begin
      reportTest();
      $display("%0d tests, %0d checks, %0d errors", testsDone, totalChecks, errorCount);
      reportDone = 1'b1;
    end
  end

endmodule

/* verification/md5CrackTb.sv */
`timescale 1ns/10ps

module md5CrackTb;
  import md5Pkg::*;

  `include "md5RefModel.svh"

  localparam int StepsPerCycle = 1;
  localparam int Latency = NumSteps / StepsPerCycle + 2;
  localparam int ClockPeriod = 8;
  localparam int ResetCycles = 10;
  localparam int QuietLen = 20;
  localparam int PlantLen = 40;
  localparam int StreamLen = 400;
  localparam int BurstLen = 60;
  // each test loads, waits one latency, streams, then drains
  localparam int RunCycles = ResetCycles + QuietLen + PlantLen + StreamLen + BurstLen + 10 +
                             5 * (2 * Latency + 10);
  localparam int WatchdogCycles = RunCycles + Latency + 100;

  logic    CLK;
  logic    reset;
  word_t   candidate;
  logic    candidateValid;
  digest_t target;
  logic    targetLoad;
  logic    found;
  word_t   matchCandidate;
  int      testId;
  logic    runDone;
  int      errorCount;
  logic    reportDone;
  logic [31:0] lfsrState;

  md5CrackTop #(
    .StepsPerCycle(StepsPerCycle)
  ) md5CrackTop_i (
    .CLK(CLK),
    .reset(reset),
    .candidate(candidate),
    .candidateValid(candidateValid),
    .target(target),
    .targetLoad(targetLoad),
    .found(found),
    .matchCandidate(matchCandidate)
  );

  md5Checker #(
    .StepsPerCycle(StepsPerCycle)
  ) md5Checker_i (
    .CLK(CLK),
    .reset(reset),
    .candidate(candidate),
    .candidateValid(candidateValid),
    .target(target),
    .targetLoad(targetLoad),
    .found(found),
    .matchCandidate(matchCandidate),
    .testId(testId),
    .runDone(runDone),
    .errorCount(errorCount),
    .reportDone(reportDone)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(ClockPeriod / 2) CLK = ~CLK;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  task automatic issue(input logic v, input word_t c);
    @(posedge CLK);
    candidateValid <= v;
    candidate <= c;
  endtask

  task automatic idle(input int n);
    repeat (n) issue(1'b0, '0);
  endtask

  task automatic streamRandom(input int n);
    repeat (n) issue(1'b1, randomBits(32));
  endtask

  task automatic loadTarget(input digest_t t);
    @(posedge CLK);
    candidateValid <= 1'b0;
    targetLoad <= 1'b1;
    target <= t;
    @(posedge CLK);
    targetLoad <= 1'b0;
  endtask

  task automatic endTest(input logic last);
    idle(Latency + 4);
    @(posedge CLK);
    if (last)
      runDone <= 1'b1;
    else
      testId <= testId + 1;
  endtask

  //********************************************************************
  // test sequence
  //********************************************************************

  initial
  begin
    word_t quiet;
    word_t planted;
    word_t fresh;
    lfsrState = 32'h27cd_e3d1;
    quiet = randomBits(32);
    reset <= 1'b1;
    // a matching item held valid through reset must never surface
    candidate <= quiet;
    candidateValid <= 1'b1;
    target <= '0;
    targetLoad <= 1'b0;
    testId <= 1;
    runDone <= 1'b0;
    repeat (ResetCycles) @(posedge CLK);
    reset <= 1'b0;
    candidateValid <= 1'b0;
    loadTarget(md5Digest(quiet));
    streamRandom(QuietLen);
    endTest(1'b0);

    planted = randomBits(32);
    loadTarget(md5Digest(planted));
    idle(Latency);
    for (int i = 0; i < PlantLen; i++)
      issue(1'b1, (i == PlantLen / 2) ? planted : randomBits(32));
    endTest(1'b0);

    loadTarget({randomBits(32), randomBits(32), randomBits(32), randomBits(32)});
    idle(Latency);
    streamRandom(StreamLen);
    endTest(1'b0);

    // back to back hits, then random gaps
    loadTarget(md5Digest(planted));
    idle(Latency);
    repeat (6) issue(1'b1, planted);
    for (int i = 0; i < BurstLen; i++)
      issue(randomBits(1) != 0, planted);
    endTest(1'b0);

    fresh = randomBits(32);
    loadTarget(md5Digest(fresh));
    idle(Latency);
    issue(1'b1, planted);
    issue(1'b1, randomBits(32));
    issue(1'b1, fresh);
    endTest(1'b1);

    while (!reportDone)
      @(posedge CLK);
    if (errorCount == 0 && md5CrackTop_i.md5Crack_props_i.assertFailures == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    repeat (WatchdogCycles) @(posedge CLK);
    $display("watchdog expired after %0d cycles, run did not finish", WatchdogCycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verification/md5Crack_props.sv */
`timescale 1ns/10ps

module md5Crack_props #(
  parameter int StepsPerCycle = 1
) (
  input logic          CLK,
  input logic          reset,
  input logic          candidateValid,
  input logic          found,
  input md5Pkg::word_t matchCandidate
);
  import md5Pkg::*;

  localparam int Latency = NumSteps / StepsPerCycle + 2;

  int assertFailures = 0;

  // low through reset and one cycle past it
  resetQuiet: assert property (@(posedge CLK) ($past(reset) || $past(reset, 2)) |-> !found)
    else
    begin
      assertFailures++;
      $error("found high during reset or the cycle after");
    end

  foundHasSource: assert property (@(posedge CLK) disable iff (reset)
    found |-> $past(candidateValid, Latency))
    else
    begin
      assertFailures++;
      $error("found high without a valid candidate one latency earlier");
    end

  matchHolds: assert property (@(posedge CLK) disable iff (reset)
    (!found && !$isunknown($past(matchCandidate))) |-> matchCandidate == $past(matchCandidate))
    else
    begin
      assertFailures++;
      $error("matchCandidate changed without found");
    end

endmodule

bind md5CrackTop md5Crack_props #(
  .StepsPerCycle(StepsPerCycle)
) md5Crack_props_i (
  .CLK(CLK),
  .reset(reset),
  .candidateValid(candidateValid),
  .found(found),
  .matchCandidate(matchCandidate)
);
